// File: tests/eth_mac_tests.txt
# speed(10|100) ethernet_II(0|1) dest(0 own, 1 foreign) length err_byte(-1 none)
# outcome(0 received, 1 filtered, 2 error)
100 0 0 8 -1 0
100 1 0 16 -1 0
10 0 0 5 -1 0
10 1 0 3 -1 0
100 0 1 6 -1 1
10 1 1 4 -1 1
100 0 0 10 4 2
100 0 0 7 -1 0
10 0 0 6 2 2
10 1 0 9 -1 0
100 1 0 1 -1 0
100 0 0 12 0 2
100 1 0 12 -1 0
100 0 0 16 -1 0

// File: filelist.f
source/eth_pkg.sv
source/eth_tick_gen.sv
source/eth_regs.sv
source/eth_tx.sv
source/eth_rx.sv
source/eth_mac.sv
tests/eth_mac_properties.sv
tests/eth_mac_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = eth_mac_tb
FILELIST  = filelist.f
BUILD     = obj_dir
BIN       = $(BUILD)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Test failed" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: tests/eth_mac_tb.sv
`default_nettype none

module eth_mac_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import eth_pkg::*;

    localparam mac_addr_t OWN_MAC     = 48'h02_1a_2b_3c_4d_5e;
    localparam mac_addr_t FOREIGN_MAC = 48'h02_1a_2b_3c_4d_00;
    localparam int        MAX_LINES   = 32;

    logic clk, rst_n, req, write, ack, error, interrupt;
    reg_addr_t address;
    logic [31:0] wdata, rdata;
    logic [1:0] txd, rxd;
    logic txen, crsdv, rxer, refclk;
    int sp [MAX_LINES];  // 10 or 100
    int e2 [MAX_LINES];
    int fr [MAX_LINES];  // 1 sends to a foreign address
    int ln [MAX_LINES];
    int ei [MAX_LINES];  // payload byte hit by rxer or -1 for none
    int oc [MAX_LINES];  // 0 received, 1 filtered, 2 error
    int errors, checks, seed, n_lines, limit_ns, inject_idx, tick_cycles;

    eth_mac #(
        .MAC_ADDRESS    ( OWN_MAC ),
        .TX_BUFFER_SIZE ( 16      ),
        .RX_BUFFER_SIZE ( 16      )
    ) uut (
        .clk_i         ( clk       ),
        .rst_n_i       ( rst_n     ),
        .req_i         ( req       ),
        .write_i       ( write     ),
        .address_i     ( address   ),
        .wdata_i       ( wdata     ),
        .ack_o         ( ack       ),
        .rdata_o       ( rdata     ),
        .error_o       ( error     ),
        .interrupt_o   ( interrupt ),
        .rmii_rxd_i    ( rxd       ),
        .rmii_crsdv_i  ( crsdv     ),
        .rmii_rxer_i   ( rxer      ),
        .rmii_txd_o    ( txd       ),
        .rmii_txen_o   ( txen      ),
        .rmii_refclk_o ( refclk    )
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = !clk;
    end

    // reference clock is low in reset and toggles on every edge after it
    initial begin
        int edges;
        edges = 0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            #2;
            edges++;
            check(32'(refclk), 32'(edges % 2), "reference clock phase");
        end
    end

    // loopback where rxer covers the four dibits of one payload byte
    initial begin
        int txen_cycles;
        txen_cycles = 0;
        rxd   = 2'b00;
        crsdv = 1'b0;
        rxer  = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            txen_cycles = txen ? txen_cycles + 1 : 0;
            rxd   = txd;
            crsdv = txen;
            rxer  = txen && inject_idx >= 0
                    && (txen_cycles - 1) / (4 * tick_cycles) == 22 + inject_idx;
        end
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic report_and_finish();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // four-phase access that starts and ends 2 ns after a rising edge
    task automatic reg_access(input logic wr, input reg_addr_t addr, input logic [31:0] data,
                              output logic [31:0] rd_data, output logic err);
        int waited;
        waited  = 0;
        req     = 1'b1;
        write   = wr;
        address = addr;
        wdata   = data;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (!ack && waited < 8);
        if (!ack) begin
            errors++;
            $display("no ack from the DUT for address %0d at %0d ns", addr, $time);
        end else begin
            check(waited, 1, "ack latency");
        end
        rd_data = rdata;
        err     = error;
        req     = 1'b0;
        waited  = 0;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (ack && waited < 8);
        if (ack) begin
            errors++;
            $display("ack stayed high after the request ended at %0d ns", $time);
        end
    endtask

    task automatic reg_write(input reg_addr_t addr, input logic [31:0] data);
        logic [31:0] unused;
        logic err;
        reg_access(1'b1, addr, data, unused, err);
        check(32'(err), 0, "error flag on a valid write");
    endtask

    task automatic reg_read(input reg_addr_t addr, output logic [31:0] data);
        logic err;
        reg_access(1'b0, addr, 32'h0, data, err);
        check(32'(err), 0, "error flag on a valid read");
    endtask

    task automatic load_tests();
        logic [8*96-1:0] text;
        int fd, v_sp, v_e2, v_fr, v_ln, v_ei, v_oc;
        fd = $fopen("tests/eth_mac_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the test data file tests/eth_mac_tests.txt");
        end else begin
            while (n_lines < MAX_LINES && $fgets(text, fd) != 0) begin
                if ($sscanf(text, "%d %d %d %d %d %d",
                            v_sp, v_e2, v_fr, v_ln, v_ei, v_oc) == 6) begin
                    sp[n_lines] = v_sp;
                    e2[n_lines] = v_e2;
                    fr[n_lines] = v_fr;
                    ln[n_lines] = v_ln;
                    ei[n_lines] = v_ei;
                    oc[n_lines] = v_oc;
                    n_lines++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic register_checks();
        ctrl_word_t ctrl;
        desc_word_t desc;
        logic [31:0] word;
        logic err;
        ctrl             = '0;
        ctrl.rx_enable   = 1'b1;
        ctrl.speed       = SPEED_100;
        ctrl.ethernet_II = 1'b1;
        ctrl.irq_enable  = 1'b1;
        reg_write(REG_CTRL, ctrl);
        reg_read(REG_CTRL, word);
        check(word, ctrl, "CTRL read back");
        desc.dest_hi = 16'hbeef;
        desc.length  = 16'd12;
        reg_write(REG_TX_DESC, desc);
        reg_read(REG_TX_DESC, word);
        check(word, desc, "TX_DESC read back");
        reg_access(1'b0, 4'd9, 32'h0, word, err);
        check(32'(err), 1, "error flag on a read of address 9");
        reg_access(1'b1, 4'd9, 32'h1234, word, err);
        check(32'(err), 1, "error flag on a write to address 9");
        reg_access(1'b1, REG_STATUS, 32'h0, word, err);  // read-only register
        check(32'(err), 1, "error flag on a STATUS write");
    endtask

    task automatic run_frame(input int idx);
        logic [7:0] payload [16];
        ctrl_word_t ctrl;
        desc_word_t desc;
        mac_addr_t dest;
        logic [31:0] st, word;
        logic seen_err;
        int n;
        dest         = fr[idx] ? FOREIGN_MAC : OWN_MAC;
        desc.dest_hi = dest[47:32];
        desc.length  = 16'(ln[idx]);
        reg_write(REG_TX_DEST_LO, dest[31:0]);
        reg_write(REG_TX_DESC, desc);
        for (int i = 0; i < ln[idx]; i++) begin
            payload[i] = 8'($random(seed));
            reg_write(REG_TX_DATA, {24'h0, payload[i]});
        end
        tick_cycles      = (sp[idx] == 100) ? 2 : 20;
        inject_idx       = ei[idx];
        ctrl             = '0;
        ctrl.rx_enable   = 1'b1;
        ctrl.speed       = (sp[idx] == 100) ? SPEED_100 : SPEED_10;
        ctrl.ethernet_II = (e2[idx] != 0);
        ctrl.irq_enable  = 1'b1;
        reg_write(REG_CTRL, ctrl);  // settle speed first
        ctrl.tx_start = 1'b1;
        reg_write(REG_CTRL, ctrl);
        seen_err = 1'b0;
        do begin
            reg_read(REG_STATUS, st);
            seen_err |= st[2];  // sticky bit clears on every read
        end while (!st[0]);
        inject_idx = -1;
        if (oc[idx] == 0) begin
            n = 0;
            while (!interrupt && n < 4 * tick_cycles + 8) begin
                @(posedge clk);
                #2;
                n++;
            end
            check(32'(interrupt), 1, "interrupt after a received frame");
            reg_read(REG_STATUS, st);
            check(32'(st[1]), 1, "frame_ready");
            check(32'(st[2] | seen_err), 0, "rx_error on a clean frame");
            check(32'(st[15:8]), ln[idx], "received byte count");
            check(32'(interrupt), 0, "interrupt after the STATUS read");
            reg_read(REG_RX_SRC_LO, word);
            check(word, OWN_MAC[31:0], "source address low");
            reg_read(REG_RX_SRC_HI, word);
            check(32'(word[31:16]), 32'(OWN_MAC[47:32]), "source address high");
            check(32'(word[15:0]), e2[idx] ? 32'h0800 : ln[idx], "length/type");
            for (int i = 0; i < ln[idx]; i++) begin
                reg_read(REG_RX_DATA, word);
                check(32'(word[7:0]), 32'(payload[i]), "payload byte");
            end
            reg_read(REG_STATUS, st);
            check(32'(st[1]), 0, "frame_ready after the buffer is read out");
        end else begin
            repeat (4 * tick_cycles + 8) @(posedge clk);  // margin for a late frame_ready
            #2;
            check(32'(interrupt), 0, "interrupt on a dropped frame");
            reg_read(REG_STATUS, st);
            check(32'(st[1]), 0, "frame_ready on a dropped frame");
            check(32'(st[2] | seen_err), (oc[idx] == 2) ? 1 : 0, "rx_error");
        end
    endtask

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        errors++;
        $display("timeout, the tests did not finish within %0d ns", limit_ns);
        report_and_finish();
    end

    initial begin
        int total;
        rst_n       = 1'b0;
        req         = 1'b0;
        write       = 1'b0;
        address     = REG_CTRL;
        wdata       = '0;
        errors      = 0;
        checks      = 0;
        seed        = 32'h3d38;
        n_lines     = 0;
        limit_ns    = 0;
        inject_idx  = -1;
        tick_cycles = 2;
        load_tests();
        total = 50000;
        for (int i = 0; i < n_lines; i++) begin
            total += (22 + ln[i]) * 4 * ((sp[i] == 100) ? 2 : 20) * 20 + 20000;
        end
        limit_ns = total;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        check(32'(ack), 0, "ack_o after reset");
        check(32'(error), 0, "error_o after reset");
        check(32'(interrupt), 0, "interrupt_o after reset");
        check(32'(txen), 0, "rmii_txen_o after reset");
        register_checks();
        for (int i = 0; i < n_lines; i++) begin
            run_frame(i);
        end
        report_and_finish();
    end

endmodule : eth_mac_tb

`default_nettype wire

// File: tests/eth_mac_properties.sv
`default_nettype none

module eth_mac_properties (
    input logic clk_i,
    input logic rst_n_i,
    input logic req_i,
    input logic ack_i,
    input logic error_i,
    input logic tick_i,
    input logic txen_i
);
    timeunit 1ns;
    timeprecision 100ps;

    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_i) |-> $past(req_i))
        else $error("ack_o rose without a request");

    ack_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ack_i && req_i) |=> ack_i)
        else $error("ack_o dropped while req_i was still high");

    txen_on_tick: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (txen_i != $past(txen_i)) |-> $past(tick_i))
        else $error("rmii_txen_o changed outside the cycle after a tick");

    error_with_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        error_i |-> ack_i)
        else $error("error_o high without ack_o");

endmodule : eth_mac_properties

bind eth_mac eth_mac_properties u_props (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .req_i   ( req_i       ),
    .ack_i   ( ack_o       ),
    .error_i ( error_o     ),
    .tick_i  ( tick        ),
    .txen_i  ( rmii_txen_o )
);

`default_nettype wire

// File: source/eth_mac.sv
`default_nettype none

module eth_mac #(
    parameter eth_pkg::mac_addr_t MAC_ADDRESS    = 48'h02_00_00_00_00_01,
    parameter int                 TX_BUFFER_SIZE = 16,
    parameter int                 RX_BUFFER_SIZE = 16
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               req_i,
    input  logic               write_i,
    input  eth_pkg::reg_addr_t address_i,
    input  logic [31:0]        wdata_i,
    output logic               ack_o,
    output logic [31:0]        rdata_o,
    output logic               error_o,
    output logic               interrupt_o,
    input  logic [1:0]         rmii_rxd_i,
    input  logic               rmii_crsdv_i,
    input  logic               rmii_rxer_i,
    output logic [1:0]         rmii_txd_o,
    output logic               rmii_txen_o,
    output logic               rmii_refclk_o
);
    import eth_pkg::*;

    eth_speed_t speed;
    tx_frame_t tx_frame;
    rx_frame_t rx_info;
    logic tick, tx_start, tx_pop, tx_busy;
    logic rx_wr, rx_done, rx_err, rx_enable, rx_hold;
    logic [7:0] tx_byte, rx_byte;

    eth_tick_gen u_tick (
        .clk_i    ( clk_i         ),
        .rst_n_i  ( rst_n_i       ),
        .speed_i  ( speed         ),
        .tick_o   ( tick          ),
        .refclk_o ( rmii_refclk_o )
    );

    eth_regs #(
        .TX_BUFFER_SIZE ( TX_BUFFER_SIZE ),
        .RX_BUFFER_SIZE ( RX_BUFFER_SIZE )
    ) u_regs (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .req_i       ( req_i       ),
        .write_i     ( write_i     ),
        .address_i   ( address_i   ),
        .wdata_i     ( wdata_i     ),
        .ack_o       ( ack_o       ),
        .rdata_o     ( rdata_o     ),
        .error_o     ( error_o     ),
        .interrupt_o ( interrupt_o ),
        .speed_o     ( speed       ),
        .tx_frame_o  ( tx_frame    ),
        .tx_start_o  ( tx_start    ),
        .tx_byte_o   ( tx_byte     ),
        .tx_pop_i    ( tx_pop      ),
        .tx_busy_i   ( tx_busy     ),
        .rx_wr_i     ( rx_wr       ),
        .rx_byte_i   ( rx_byte     ),
        .rx_done_i   ( rx_done     ),
        .rx_err_i    ( rx_err      ),
        .rx_info_i   ( rx_info     ),
        .rx_enable_o ( rx_enable   ),
        .rx_hold_o   ( rx_hold     )
    );

    eth_tx #(.MAC_ADDRESS(MAC_ADDRESS)) u_tx (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .tick_i      ( tick        ),
        .start_i     ( tx_start    ),
        .frame_i     ( tx_frame    ),
        .byte_i      ( tx_byte     ),
        .pop_o       ( tx_pop      ),
        .busy_o      ( tx_busy     ),
        .rmii_txd_o  ( rmii_txd_o  ),
        .rmii_txen_o ( rmii_txen_o )
    );

    eth_rx #(.MAC_ADDRESS(MAC_ADDRESS)) u_rx (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .tick_i       ( tick         ),
        .enable_i     ( rx_enable    ),
        .hold_i       ( rx_hold      ),
        .rmii_rxd_i   ( rmii_rxd_i   ),
        .rmii_crsdv_i ( rmii_crsdv_i ),
        .rmii_rxer_i  ( rmii_rxer_i  ),
        .wr_o         ( rx_wr        ),
        .byte_o       ( rx_byte      ),
        .done_o       ( rx_done      ),
        .err_o        ( rx_err       ),
        .info_o       ( rx_info      )
    );

endmodule : eth_mac

`default_nettype wire

// File: source/eth_rx.sv
`default_nettype none

module eth_rx #(
    parameter eth_pkg::mac_addr_t MAC_ADDRESS = 48'h02_00_00_00_00_01
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               tick_i,
    input  logic               enable_i,
    input  logic               hold_i,
    input  logic [1:0]         rmii_rxd_i,
    input  logic               rmii_crsdv_i,
    input  logic               rmii_rxer_i,
    output logic               wr_o,
    output logic [7:0]         byte_o,
    output logic               done_o,
    output logic               err_o,
    output eth_pkg::rx_frame_t info_o
);
    import eth_pkg::*;

    typedef enum logic [1:0] {
        IDLE, HUNT, RECV, DROP
    } rx_state_t;

    localparam logic [3:0] HDR_BYTES = 4'd14;

    rx_state_t state;
    logic [3:0] sync1, sync2;  // {rxer, crs_dv, rxd}
    logic [1:0] rxd;
    logic crs, rxer;
    logic [1:0] dibit_cnt;
    logic [3:0] byte_idx;  // saturates once the header is in
    logic [7:0] shift_q, new_byte, count_q;
    logic [63:0] hdr_q;  // source and length/type
    logic byte_end;

    assign {rxer, crs, rxd} = sync2;
    assign new_byte = {rxd, shift_q[7:2]};
    assign byte_end = tick_i && state == RECV && crs && !rxer && dibit_cnt == 2'd3;
    assign info_o   = {hdr_q, count_q};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sync1 <= '0;
            sync2 <= '0;
        end else begin
            sync1 <= {rmii_rxer_i, rmii_crsdv_i, rmii_rxd_i};
            sync2 <= sync1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state     <= IDLE;
            dibit_cnt <= '0;
            byte_idx  <= '0;
            count_q   <= '0;
            wr_o      <= 1'b0;
            done_o    <= 1'b0;
            err_o     <= 1'b0;
        end else begin
            wr_o   <= 1'b0;
            done_o <= 1'b0;
            err_o  <= 1'b0;
            if (tick_i) begin
                case (state)
                    IDLE: if (crs) state <= (enable_i && !hold_i) ? HUNT : DROP;
                    HUNT: begin
                        if (!crs) begin
                            state <= IDLE;
                        end else if (rxd == 2'b11) begin  // last dibit of the SFD
                            state     <= RECV;
                            dibit_cnt <= '0;
                            byte_idx  <= '0;
                            count_q   <= '0;
                        end
                    end
                    RECV: begin
                        if (!crs) begin
                            done_o <= (byte_idx == HDR_BYTES);
                            err_o  <= (byte_idx != HDR_BYTES);  // runt header
                            state  <= IDLE;
                        end else if (rxer) begin
                            err_o <= 1'b1;
                            state <= DROP;
                        end else begin
                            dibit_cnt <= dibit_cnt + 2'd1;
                            if (dibit_cnt == 2'd3) begin
                                if (byte_idx != HDR_BYTES) begin
                                    byte_idx <= byte_idx + 4'd1;
                                end else begin
                                    wr_o    <= 1'b1;
                                    count_q <= count_q + 8'd1;
                                end
                                if (byte_idx == 4'd5 && {hdr_q[39:0], new_byte} != MAC_ADDRESS)
                                    state <= DROP;  // not for us
                            end
                        end
                    end
                    default: if (!crs) state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (tick_i && state == RECV) shift_q <= new_byte;
        if (byte_end && byte_idx != HDR_BYTES) hdr_q <= {hdr_q[55:0], new_byte};
        if (byte_end) byte_o <= new_byte;
    end

endmodule : eth_rx

`default_nettype wire

// File: source/eth_tx.sv
`default_nettype none

module eth_tx #(
    parameter eth_pkg::mac_addr_t MAC_ADDRESS = 48'h02_00_00_00_00_01
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               tick_i,
    input  logic               start_i,
    input  eth_pkg::tx_frame_t frame_i,
    input  logic [7:0]         byte_i,
    output logic               pop_o,
    output logic               busy_o,
    output logic [1:0]         rmii_txd_o,
    output logic               rmii_txen_o
);
    import eth_pkg::*;

    typedef enum logic [2:0] {
        IDLE, PREAMBLE, SFD, DEST, SRC, LEN_TYPE, PAYLOAD
    } tx_state_t;

    tx_state_t state, next_state;
    tx_frame_t frame_q;
    logic [15:0] byte_cnt, last_idx, len_type;
    logic [1:0] dibit_cnt;
    logic [7:0] cur_byte;

    assign len_type = frame_q.ethernet_II ? ETH_TYPE_IPV4 : frame_q.length;
    assign busy_o   = (state != IDLE) || rmii_txen_o;  // txen still drops on a tick

    // byte on the wire and the last byte index of each field
    always_comb begin
        cur_byte   = 8'h00;
        last_idx   = '0;
        next_state = IDLE;
        case (state)
            PREAMBLE: begin
                cur_byte   = 8'h55;
                last_idx   = 16'(PREAMBLE_BYTES - 1);
                next_state = SFD;
            end
            SFD: begin
                cur_byte   = ETH_SFD;
                next_state = DEST;
            end
            DEST: begin
                cur_byte   = frame_q.dest[8*(3'd5 - byte_cnt[2:0]) +: 8];  // msb byte first
                last_idx   = 16'd5;
                next_state = SRC;
            end
            SRC: begin
                cur_byte   = MAC_ADDRESS[8*(3'd5 - byte_cnt[2:0]) +: 8];
                last_idx   = 16'd5;
                next_state = LEN_TYPE;
            end
            LEN_TYPE: begin
                cur_byte   = byte_cnt[0] ? len_type[7:0] : len_type[15:8];
                last_idx   = 16'd1;
                next_state = (frame_q.length == '0) ? IDLE : PAYLOAD;
            end
            PAYLOAD: begin
                cur_byte = byte_i;
                last_idx = frame_q.length - 16'd1;
            end
            default: cur_byte = 8'h00;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state       <= IDLE;
            byte_cnt    <= '0;
            dibit_cnt   <= '0;
            pop_o       <= 1'b0;
            rmii_txd_o  <= '0;
            rmii_txen_o <= 1'b0;
        end else begin
            pop_o <= tick_i && state == PAYLOAD && dibit_cnt == 2'd3;
            if (state == IDLE) begin
                if (tick_i) begin
                    rmii_txen_o <= 1'b0;
                    rmii_txd_o  <= '0;
                end
                if (start_i) begin
                    state     <= PREAMBLE;
                    byte_cnt  <= '0;
                    dibit_cnt <= '0;
                end
            end else if (tick_i) begin
                rmii_txen_o <= 1'b1;
                rmii_txd_o  <= cur_byte[2*dibit_cnt +: 2];  // lsb dibit first
                dibit_cnt   <= dibit_cnt + 2'd1;
                if (dibit_cnt == 2'd3) begin
                    if (byte_cnt == last_idx) begin
                        byte_cnt <= '0;
                        state    <= next_state;
                    end else begin
                        byte_cnt <= byte_cnt + 16'd1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i && state == IDLE) frame_q <= frame_i;  // hold for the whole frame
    end

endmodule : eth_tx

`default_nettype wire

// File: source/eth_regs.sv
`default_nettype none

module eth_regs #(
    parameter int TX_BUFFER_SIZE = 16,
    parameter int RX_BUFFER_SIZE = 16
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                req_i,
    input  logic                write_i,
    input  eth_pkg::reg_addr_t  address_i,
    input  logic [31:0]         wdata_i,
    output logic                ack_o,
    output logic [31:0]         rdata_o,
    output logic                error_o,
    output logic                interrupt_o,
    output eth_pkg::eth_speed_t speed_o,
    output eth_pkg::tx_frame_t  tx_frame_o,
    output logic                tx_start_o,
    output logic [7:0]          tx_byte_o,
    input  logic                tx_pop_i,
    input  logic                tx_busy_i,
    input  logic                rx_wr_i,
    input  logic [7:0]          rx_byte_i,
    input  logic                rx_done_i,
    input  logic                rx_err_i,
    input  eth_pkg::rx_frame_t  rx_info_i,
    output logic                rx_enable_o,
    output logic                rx_hold_o
);
    import eth_pkg::*;

    localparam int TXW = $clog2(TX_BUFFER_SIZE);
    localparam int RXW = $clog2(RX_BUFFER_SIZE);

    logic [7:0] tx_mem [TX_BUFFER_SIZE];
    logic [7:0] rx_mem [RX_BUFFER_SIZE];
    logic [TXW:0] tx_wr_ptr, tx_rd_ptr;  // extra bit tells full from empty
    logic [RXW:0] rx_wr_ptr, rx_rd_ptr, rx_level;
    tx_frame_t frame_q;
    rx_frame_t info_q;
    logic rx_enable_q, irq_enable_q, frame_ready_q, rx_error_q, irq_q;
    reg_word_u wword, rword;
    logic access, acc_err, wr_ok, rd_ok, tx_idle;

    assign wword    = wdata_i;
    assign access   = req_i && !ack_o;  // one access per request
    assign wr_ok    = access && write_i && !acc_err;
    assign rd_ok    = access && !write_i && !acc_err;
    assign rx_level = rx_wr_ptr - rx_rd_ptr;
    assign tx_idle  = !tx_busy_i && !tx_start_o;

    always_comb begin
        rword   = '0;
        acc_err = 1'b0;
        case (address_i)
            REG_CTRL: begin
                rword.ctrl.rx_enable   = rx_enable_q;
                rword.ctrl.speed       = frame_q.speed;
                rword.ctrl.ethernet_II = frame_q.ethernet_II;
                rword.ctrl.irq_enable  = irq_enable_q;
            end
            REG_TX_DESC: begin
                rword.desc.dest_hi = frame_q.dest[47:32];
                rword.desc.length  = frame_q.length;
            end
            REG_TX_DEST_LO: rword = frame_q.dest[31:0];
            REG_TX_DATA:    acc_err = !write_i;
            REG_STATUS: begin
                rword   = {16'h0, info_q.count, 5'h0, rx_error_q, frame_ready_q, tx_idle};
                acc_err = write_i;
            end
            REG_RX_SRC_LO: begin
                rword   = info_q.src[31:0];
                acc_err = write_i;
            end
            REG_RX_SRC_HI: begin
                rword   = {info_q.src[47:32], info_q.len_type};
                acc_err = write_i;
            end
            REG_RX_DATA: begin
                rword   = {24'h0, rx_mem[rx_rd_ptr[RXW-1:0]]};
                acc_err = write_i;
            end
            default: acc_err = 1'b1;
        endcase
    end

    // four-phase slave, ack follows req by one cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_o   <= 1'b0;
            error_o <= 1'b0;
            rdata_o <= '0;
        end else if (access) begin
            ack_o   <= 1'b1;
            error_o <= acc_err;
            rdata_o <= write_i ? 32'h0 : rword;
        end else if (!req_i) begin
            ack_o   <= 1'b0;
            error_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            frame_q       <= '0;
            info_q        <= '0;
            rx_enable_q   <= 1'b0;
            irq_enable_q  <= 1'b0;
            frame_ready_q <= 1'b0;
            rx_error_q    <= 1'b0;
            irq_q         <= 1'b0;
            tx_start_o    <= 1'b0;
            tx_wr_ptr     <= '0;
            tx_rd_ptr     <= '0;
            rx_wr_ptr     <= '0;
            rx_rd_ptr     <= '0;
        end else begin
            tx_start_o <= 1'b0;
            if (wr_ok && address_i == REG_CTRL) begin
                tx_start_o          <= wword.ctrl.tx_start && !tx_busy_i && !tx_start_o;
                rx_enable_q         <= wword.ctrl.rx_enable;
                frame_q.speed       <= wword.ctrl.speed;
                frame_q.ethernet_II <= wword.ctrl.ethernet_II;
                irq_enable_q        <= wword.ctrl.irq_enable;
            end
            if (wr_ok && address_i == REG_TX_DESC) begin
                frame_q.dest[47:32] <= wword.desc.dest_hi;
                frame_q.length      <= wword.desc.length;
            end
            if (wr_ok && address_i == REG_TX_DEST_LO) frame_q.dest[31:0] <= wdata_i;
            if (wr_ok && address_i == REG_TX_DATA) tx_wr_ptr <= tx_wr_ptr + 1'b1;
            if (tx_pop_i) tx_rd_ptr <= tx_rd_ptr + 1'b1;

            if (rd_ok && address_i == REG_STATUS) begin
                irq_q      <= 1'b0;
                rx_error_q <= 1'b0;
            end
            if (rd_ok && address_i == REG_RX_DATA) begin
                if (rx_level != '0) rx_rd_ptr <= rx_rd_ptr + 1'b1;
                if (rx_level <= 1) frame_ready_q <= 1'b0;  // last byte read out
            end
            if (rx_err_i) begin
                rx_wr_ptr  <= rx_rd_ptr;  // drop the partial frame
                rx_error_q <= 1'b1;
            end else if (rx_wr_i) begin
                rx_wr_ptr <= rx_wr_ptr + 1'b1;
            end
            if (rx_done_i) begin
                frame_ready_q <= 1'b1;
                irq_q         <= 1'b1;
                info_q        <= rx_info_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_ok && address_i == REG_TX_DATA) tx_mem[tx_wr_ptr[TXW-1:0]] <= wdata_i[7:0];
        if (rx_wr_i) rx_mem[rx_wr_ptr[RXW-1:0]] <= rx_byte_i;
    end

    assign interrupt_o = irq_q && irq_enable_q;
    assign speed_o     = frame_q.speed;
    assign tx_frame_o  = frame_q;
    assign tx_byte_o   = tx_mem[tx_rd_ptr[TXW-1:0]];  // head of the TX buffer
    assign rx_enable_o = rx_enable_q;
    assign rx_hold_o   = frame_ready_q;

endmodule : eth_regs

`default_nettype wire

// File: source/eth_tick_gen.sv
`default_nettype none

module eth_tick_gen (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  eth_pkg::eth_speed_t speed_i,
    output logic                tick_o,
    output logic                refclk_o
);
    import eth_pkg::*;

    logic [4:0] count;
    eth_speed_t speed_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count    <= '0;
            refclk_o <= 1'b0;
            speed_q  <= SPEED_10;
        end else begin
            refclk_o <= !refclk_o;  // 50 MHz from the 100 MHz system clock
            speed_q  <= speed_i;
            if (speed_i != speed_q || count == 5'd19) begin
                count <= '0;  // restart the phase on a speed change
            end else begin
                count <= count + 5'd1;
            end
        end
    end

    assign tick_o = (speed_q == SPEED_100) ? count[0] : (count == 5'd19);

endmodule : eth_tick_gen

`default_nettype wire

// File: source/eth_pkg.sv
`default_nettype none

package eth_pkg;

    typedef enum logic {
        SPEED_10  = 1'b0,
        SPEED_100 = 1'b1
    } eth_speed_t;

    typedef logic [3:0] reg_addr_t;

    localparam reg_addr_t REG_CTRL       = 4'd0;  // r/w, control view
    localparam reg_addr_t REG_TX_DESC    = 4'd1;  // r/w, descriptor view
    localparam reg_addr_t REG_TX_DEST_LO = 4'd2;  // r/w
    localparam reg_addr_t REG_TX_DATA    = 4'd3;  // write only, pushes one byte
    localparam reg_addr_t REG_STATUS     = 4'd4;  // read only
    localparam reg_addr_t REG_RX_SRC_LO  = 4'd5;  // read only
    localparam reg_addr_t REG_RX_SRC_HI  = 4'd6;  // read only
    localparam reg_addr_t REG_RX_DATA    = 4'd7;  // read only, pops one byte

    typedef struct packed {
        logic [26:0] reserved;
        logic        irq_enable;
        logic        ethernet_II;
        eth_speed_t  speed;
        logic        rx_enable;
        logic        tx_start;
    } ctrl_word_t;

    typedef struct packed {
        logic [15:0] dest_hi;  // destination bytes 0 and 1
        logic [15:0] length;
    } desc_word_t;

    typedef union packed {
        ctrl_word_t ctrl;
        desc_word_t desc;
    } reg_word_u;

    typedef logic [47:0] mac_addr_t;

    typedef struct packed {
        mac_addr_t   dest;
        logic [15:0] length;
        logic        ethernet_II;
        eth_speed_t  speed;
    } tx_frame_t;

    typedef struct packed {
        mac_addr_t   src;
        logic [15:0] len_type;
        logic [7:0]  count;  // payload bytes only
    } rx_frame_t;

    localparam logic [15:0] ETH_TYPE_IPV4  = 16'h0800;
    localparam logic [7:0]  ETH_SFD        = 8'hD5;
    localparam int          PREAMBLE_BYTES = 7;

endpackage : eth_pkg

`default_nettype wire
